// ==== verilog/sme_pkg.sv ====
`default_nettype none

package sme_pkg;

    // ======================================================================
    // Character format
    // ======================================================================

    // One text or pattern character per host write
    localparam int CHAR_W = 8;

    // ======================================================================
    // Pattern metacharacters and separators
    // ======================================================================

    // Anchor at text start or after a space, first pattern element only
    localparam logic [CHAR_W-1:0] HAT_CHAR    = 8'h5E;

    // Anchor at text end or before a space, last pattern element only
    localparam logic [CHAR_W-1:0] DOLLAR_CHAR = 8'h24;

    // Wildcard for any single character
    localparam logic [CHAR_W-1:0] DOT_CHAR    = 8'h2E;

    // Word separator seen by both anchors
    localparam logic [CHAR_W-1:0] SPACE_CHAR  = 8'h20;

endpackage

`default_nettype wire

// ==== verilog/char_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module char_buffer #(
    parameter int DEPTH = 34
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          load,
    input  logic                          restart,
    input  logic [sme_pkg::CHAR_W-1:0]    wr_data,
    input  logic [$clog2(DEPTH)-1:0]      rd_addr,
    output logic [sme_pkg::CHAR_W-1:0]    rd_data,
    output logic [$clog2(DEPTH+1)-1:0]    length
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int LEN_W  = $clog2(DEPTH + 1);

    localparam logic [LEN_W-1:0]  FULL_LEN  = LEN_W'(DEPTH);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DEPTH - 1);

    logic [sme_pkg::CHAR_W-1:0] mem [DEPTH];
    logic [ADDR_W-1:0]          wr_addr;
    logic                       wr_en;
    logic                       full;

    // ======================================================================
    // Write side
    // ======================================================================

    assign full  = (length == FULL_LEN);

    // Restart always lands on entry 0, appends stop once full
    assign wr_en   = restart || (load && !full);
    assign wr_addr = restart ? '0 : length[ADDR_W-1:0];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Number of stored characters
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            length <= '0;
        end
        else if (restart)
        begin
            length <= LEN_W'(1);
        end
        else if (load && !full)
        begin
            length <= length + 1'b1;
        end
    end

    // ======================================================================
    // Read side
    // ======================================================================

    // Addresses past the last entry read as zero
    assign rd_data = (rd_addr <= LAST_ADDR) ? mem[rd_addr] : '0;

    // Host must not append beyond capacity
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (load && !restart) |-> !full);

endmodule

`default_nettype wire

// ==== verilog/frame_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_scanner #(
    parameter int STR_DEPTH = 34,
    parameter int PAT_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              scan_start,
    input  logic [sme_pkg::CHAR_W-1:0]        str_data,
    input  logic [$clog2(STR_DEPTH+1)-1:0]    str_len,
    output logic [$clog2(STR_DEPTH)-1:0]      str_addr,
    input  logic [sme_pkg::CHAR_W-1:0]        pat_data,
    input  logic [$clog2(PAT_DEPTH+1)-1:0]    pat_len,
    output logic [$clog2(PAT_DEPTH)-1:0]      pat_addr,
    output logic                              scan_hit,
    output logic                              scan_miss,
    output logic [$clog2(STR_DEPTH)-1:0]      hit_index
);

    localparam int STR_AW = $clog2(STR_DEPTH);
    localparam int STR_LW = $clog2(STR_DEPTH + 1);
    localparam int PAT_AW = $clog2(PAT_DEPTH);
    localparam int PAT_LW = $clog2(PAT_DEPTH + 1);

    // ======================================================================
    // Scan state
    // ======================================================================

    logic              busy;
    logic [STR_LW-1:0] frame_ptr;
    logic [STR_LW-1:0] text_ptr;
    logic [PAT_LW-1:0] pat_ptr;

    // Character before the current frame is a space
    logic              prev_space;

    logic              frame_done;
    logic              pat_done;
    logic              at_end;
    logic              text_space;
    logic              first_elem;
    logic              last_elem;
    logic              is_hat;
    logic              is_dollar;
    logic              is_any;
    logic              consumes_text;
    logic              step_pass;
    logic              report_hit;
    logic              report_miss;

    assign str_addr = text_ptr[STR_AW-1:0];
    assign pat_addr = pat_ptr[PAT_AW-1:0];

    // ======================================================================
    // Element decode
    // ======================================================================

    assign frame_done = (frame_ptr == str_len);
    assign pat_done   = (pat_ptr == pat_len);
    assign at_end     = (text_ptr == str_len);
    assign text_space = !at_end && (str_data == sme_pkg::SPACE_CHAR);

    assign first_elem = (pat_ptr == '0);
    assign last_elem  = ((pat_ptr + 1'b1) == pat_len);

    // Anchors only count at the pattern edges, elsewhere literal
    assign is_hat    = first_elem && (pat_data == sme_pkg::HAT_CHAR);
    assign is_dollar = last_elem && !is_hat && (pat_data == sme_pkg::DOLLAR_CHAR);
    assign is_any    = (pat_data == sme_pkg::DOT_CHAR);

    assign consumes_text = !is_hat && !is_dollar;

    always_comb
    begin
        if (is_hat)
        begin
            step_pass = (frame_ptr == '0) || prev_space;
        end
        else if (is_dollar)
        begin
            step_pass = at_end || text_space;
        end
        else
        begin
            // Running off the text fails any character element
            step_pass = !at_end && (is_any || (pat_data == str_data));
        end
    end

    assign report_hit  = busy && pat_done && !frame_done;
    assign report_miss = busy && frame_done;

    // ======================================================================
    // Pointer walk
    // ======================================================================

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            frame_ptr  <= '0;
            text_ptr   <= '0;
            pat_ptr    <= '0;
            prev_space <= 1'b0;
        end
        else if (scan_start)
        begin
            busy       <= 1'b1;
            frame_ptr  <= '0;
            text_ptr   <= '0;
            pat_ptr    <= '0;
            prev_space <= 1'b0;
        end
        else if (busy)
        begin
            if (frame_done || pat_done)
            begin
                busy <= 1'b0;
            end
            else
            begin
                // First step of a frame reads the frame character,
                // which is what the next frame's anchor needs
                if (first_elem)
                begin
                    prev_space <= text_space;
                end

                if (step_pass)
                begin
                    pat_ptr <= pat_ptr + 1'b1;
                    if (consumes_text)
                    begin
                        text_ptr <= text_ptr + 1'b1;
                    end
                end
                else
                begin
                    // Retry one position further right
                    frame_ptr <= frame_ptr + 1'b1;
                    text_ptr  <= frame_ptr + 1'b1;
                    pat_ptr   <= '0;
                end
            end
        end
    end

    // ======================================================================
    // Result pulses
    // ======================================================================

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            scan_hit  <= 1'b0;
            scan_miss <= 1'b0;
            hit_index <= '0;
        end
        else
        begin
            scan_hit  <= report_hit;
            scan_miss <= report_miss;
            if (report_hit)
            begin
                hit_index <= frame_ptr[STR_AW-1:0];
            end
        end
    end

    // Character steps never read past the stored text
    a_text_bound: assert property (@(posedge clk) disable iff (reset)
        busy |-> (text_ptr <= str_len));

endmodule

`default_nettype wire

// ==== verilog/sme_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sme_ctrl #(
    parameter int STR_DEPTH = 34
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          isstring,
    input  logic                          ispattern,
    output logic                          load_str,
    output logic                          restart_str,
    output logic                          load_pat,
    output logic                          restart_pat,
    output logic                          scan_start,
    input  logic                          scan_hit,
    input  logic                          scan_miss,
    input  logic [$clog2(STR_DEPTH)-1:0]  hit_index,
    output logic                          valid,
    output logic                          match,
    output logic [$clog2(STR_DEPTH)-1:0]  match_index
);

    localparam logic [1:0] PH_LOAD = 2'd0;
    localparam logic [1:0] PH_SCAN = 2'd1;
    localparam logic [1:0] PH_DONE = 2'd2;

    logic [1:0] phase;
    logic       loaded;
    logic       str_fresh;
    logic       pat_fresh;
    logic       strobe;
    logic       accept;
    logic       scan_end;

    assign strobe   = isstring || ispattern;
    assign accept   = (phase != PH_SCAN);
    assign scan_end = (phase == PH_SCAN) && (scan_hit || scan_miss);

    // ======================================================================
    // Buffer write steering
    // ======================================================================

    assign restart_str = accept && isstring && str_fresh;
    assign load_str    = accept && isstring && !str_fresh;
    assign restart_pat = accept && ispattern && pat_fresh;
    assign load_pat    = accept && ispattern && !pat_fresh;

    // Next write after reset or a result starts over
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            str_fresh <= 1'b1;
            pat_fresh <= 1'b1;
        end
        else if (scan_end)
        begin
            str_fresh <= 1'b1;
            pat_fresh <= 1'b1;
        end
        else
        begin
            if (restart_str)
            begin
                str_fresh <= 1'b0;
            end
            if (restart_pat)
            begin
                pat_fresh <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Phase sequencer
    // ======================================================================

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase      <= PH_LOAD;
            loaded     <= 1'b0;
            scan_start <= 1'b0;
        end
        else
        begin
            scan_start <= 1'b0;
            case (phase)
                PH_LOAD, PH_DONE:
                begin
                    // First idle cycle after any load kicks off the scan
                    if (loaded && !strobe)
                    begin
                        phase      <= PH_SCAN;
                        scan_start <= 1'b1;
                        loaded     <= 1'b0;
                    end
                    else
                    begin
                        phase <= PH_LOAD;
                        if (strobe)
                        begin
                            loaded <= 1'b1;
                        end
                    end
                end
                PH_SCAN:
                begin
                    if (scan_end)
                    begin
                        phase <= PH_DONE;
                    end
                end
                default:
                begin
                    phase <= PH_LOAD;
                end
            endcase
        end
    end

    // ======================================================================
    // Result outputs
    // ======================================================================

    assign valid = (phase == PH_DONE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            match       <= 1'b0;
            match_index <= '0;
        end
        else if (scan_end)
        begin
            match       <= scan_hit;
            match_index <= scan_hit ? hit_index : '0;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(isstring && ispattern));

    // Host holds off from scan start until the result pulse
    a_quiet_scan: assert property (@(posedge clk) disable iff (reset)
        (phase == PH_SCAN) |-> !strobe);

endmodule

`default_nettype wire

// ==== verilog/sme_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sme_top #(
    parameter int STR_DEPTH = 34,
    parameter int PAT_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [sme_pkg::CHAR_W-1:0]    chardata,
    input  logic                          isstring,
    input  logic                          ispattern,
    output logic                          valid,
    output logic                          match,
    output logic [$clog2(STR_DEPTH)-1:0]  match_index
);

    localparam int STR_AW = $clog2(STR_DEPTH);
    localparam int STR_LW = $clog2(STR_DEPTH + 1);
    localparam int PAT_AW = $clog2(PAT_DEPTH);
    localparam int PAT_LW = $clog2(PAT_DEPTH + 1);

    // ======================================================================
    // Internal nets
    // ======================================================================

    // Buffer write controls
    logic                       load_str;
    logic                       restart_str;
    logic                       load_pat;
    logic                       restart_pat;

    // Scanner read ports
    logic [STR_AW-1:0]          str_addr;
    logic [sme_pkg::CHAR_W-1:0] str_data;
    logic [STR_LW-1:0]          str_len;
    logic [PAT_AW-1:0]          pat_addr;
    logic [sme_pkg::CHAR_W-1:0] pat_data;
    logic [PAT_LW-1:0]          pat_len;

    // Scan handshake
    logic                       scan_start;
    logic                       scan_hit;
    logic                       scan_miss;
    logic [STR_AW-1:0]          hit_index;

    // ======================================================================
    // Storage
    // ======================================================================

    char_buffer #(
        .DEPTH (STR_DEPTH)
    ) str_buffer (
        .clk     (clk),
        .reset   (reset),
        .load    (load_str),
        .restart (restart_str),
        .wr_data (chardata),
        .rd_addr (str_addr),
        .rd_data (str_data),
        .length  (str_len)
    );

    char_buffer #(
        .DEPTH (PAT_DEPTH)
    ) pat_buffer (
        .clk     (clk),
        .reset   (reset),
        .load    (load_pat),
        .restart (restart_pat),
        .wr_data (chardata),
        .rd_addr (pat_addr),
        .rd_data (pat_data),
        .length  (pat_len)
    );

    // ======================================================================
    // Search datapath and sequencing
    // ======================================================================

    frame_scanner #(
        .STR_DEPTH (STR_DEPTH),
        .PAT_DEPTH (PAT_DEPTH)
    ) frame_scanner_i (
        .clk        (clk),
        .reset      (reset),
        .scan_start (scan_start),
        .str_data   (str_data),
        .str_len    (str_len),
        .str_addr   (str_addr),
        .pat_data   (pat_data),
        .pat_len    (pat_len),
        .pat_addr   (pat_addr),
        .scan_hit   (scan_hit),
        .scan_miss  (scan_miss),
        .hit_index  (hit_index)
    );

    sme_ctrl #(
        .STR_DEPTH (STR_DEPTH)
    ) sme_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .load_str    (load_str),
        .restart_str (restart_str),
        .load_pat    (load_pat),
        .restart_pat (restart_pat),
        .scan_start  (scan_start),
        .scan_hit    (scan_hit),
        .scan_miss   (scan_miss),
        .hit_index   (hit_index),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

endmodule

`default_nettype wire

// ==== tb/sme_ref_model.svh ====
`ifndef SME_REF_MODEL_SVH
`define SME_REF_MODEL_SVH

// Lowest text position where the pattern fits, or -1 when none does
// The position is where the first element after a leading '^' lands
function automatic int first_fit(
    input logic [sme_pkg::CHAR_W-1:0] txt[$],
    input logic [sme_pkg::CHAR_W-1:0] pat[$]
);
    int                         pos;
    logic                       fits;
    logic [sme_pkg::CHAR_W-1:0] c;
    for (int f = 0; f < txt.size(); f++)
    begin
        pos  = f;
        fits = 1'b1;
        for (int p = 0; p < pat.size() && fits; p++)
        begin
            c = pat[p];
            if (p == 0 && c == sme_pkg::HAT_CHAR)
            begin
                // Start of text or just after a word break
                fits = (f == 0) || (txt[f - 1] == sme_pkg::SPACE_CHAR);
            end
            else if (p == pat.size() - 1 && c == sme_pkg::DOLLAR_CHAR)
            begin
                fits = (pos == txt.size()) || (txt[pos] == sme_pkg::SPACE_CHAR);
            end
            else
            begin
                fits = (pos < txt.size()) && (c == sme_pkg::DOT_CHAR || c == txt[pos]);
                pos++;
            end
        end
        if (fits)
        begin
            return f;
        end
    end
    return -1;
endfunction

`endif

// ==== tb/sme_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sme_tb;

    localparam int    STR_DEPTH       = 34;
    localparam int    PAT_DEPTH       = 8;
    localparam int    IDX_W           = $clog2(STR_DEPTH);
    localparam int    CLK_PERIOD      = 8;
    localparam int    RESET_CYCLES    = 5;
    localparam int    SEED            = 9834;
    localparam int    DIRECTED_RUNS   = 12;
    localparam int    RANDOM_RUNS     = 200;
    localparam int    SEARCH_CYCLES   = 2 * STR_DEPTH * PAT_DEPTH;
    localparam int    WATCHDOG_CYCLES = (DIRECTED_RUNS + RANDOM_RUNS) * SEARCH_CYCLES
                                        + RESET_CYCLES;
    // Letters plus every character the pattern language treats specially
    localparam string ALPHABET        = "ab .^$";

    logic                       clk;
    logic                       reset;
    logic [sme_pkg::CHAR_W-1:0] chardata;
    logic                       isstring;
    logic                       ispattern;
    logic                       valid;
    logic                       match;
    logic [IDX_W-1:0]           match_index;

    // Expected result of the search in flight
    logic                       exp_match;
    logic [IDX_W-1:0]           exp_index;

    logic [sme_pkg::CHAR_W-1:0] text_q[$];
    logic [sme_pkg::CHAR_W-1:0] pat_q[$];
    int                         search_count = 0;
    int                         valid_count = 0;

    `include "sme_ref_model.svh"

    sme_top #(
        .STR_DEPTH (STR_DEPTH),
        .PAT_DEPTH (PAT_DEPTH)
    ) sme_top_i (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        if (valid)
        begin
            valid_count <= valid_count + 1;
        end
    end

    // ======================================================================
    // Failure reporting
    // ======================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, want));
    endtask

    // ======================================================================
    // Result checks
    // ======================================================================

    a_match: assert property (@(posedge clk) disable iff (reset)
        valid |-> (match == exp_match))
        else report_value("match", 32'($sampled(match)), 32'(exp_match));

    a_index: assert property (@(posedge clk) disable iff (reset)
        valid |-> (match_index == exp_index))
        else report_value("match_index", 32'($sampled(match_index)), 32'(exp_index));

    a_pulse: assert property (@(posedge clk) disable iff (reset)
        valid |=> !valid)
        else abort_run("valid stayed high for more than one cycle");

    a_reset_quiet: assert property (@(posedge clk)
        reset |-> (!valid && !match && match_index == '0))
        else abort_run("outputs were not cleared while reset was asserted");

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic load_text(input string s);
        text_q.delete();
        for (int i = 0; i < s.len(); i++)
        begin
            @(negedge clk);
            ispattern = 1'b0;
            isstring  = 1'b1;
            chardata  = s[i];
            text_q.push_back(s[i]);
        end
    endtask

    task automatic load_pattern(input string s);
        pat_q.delete();
        for (int i = 0; i < s.len(); i++)
        begin
            @(negedge clk);
            isstring  = 1'b0;
            ispattern = 1'b1;
            chardata  = s[i];
            pat_q.push_back(s[i]);
        end
    endtask

    // Drop both strobes and wait for the result pulse
    task automatic run_search();
        int fit;
        int waited;
        fit       = first_fit(text_q, pat_q);
        exp_match = (fit >= 0);
        exp_index = (fit >= 0) ? IDX_W'(fit) : '0;
        waited    = 0;
        @(negedge clk);
        isstring  = 1'b0;
        ispattern = 1'b0;
        while (!valid && waited < SEARCH_CYCLES)
        begin
            @(negedge clk);
            waited++;
        end
        if (!valid)
        begin
            abort_run($sformatf("search %0d gave no result within %0d cycles",
                                search_count, SEARCH_CYCLES));
        end
        search_count++;
    endtask

    task automatic try_search(input string text, input string pat);
        load_text(text);
        load_pattern(pat);
        run_search();
    endtask

    // Text stays loaded from the previous search
    task automatic retry_pattern(input string pat);
        load_pattern(pat);
        run_search();
    endtask

    function automatic byte random_char();
        return ALPHABET[$urandom_range(0, ALPHABET.len() - 1)];
    endfunction

    task automatic random_search();
        string s;
        int    len;
        s = "";
        // Reuse the old text now and then
        if ($urandom_range(0, 3) != 0)
        begin
            len = $urandom_range(1, STR_DEPTH);
            for (int i = 0; i < len; i++)
            begin
                s = $sformatf("%s%c", s, random_char());
            end
            load_text(s);
        end
        s   = "";
        len = $urandom_range(1, PAT_DEPTH);
        for (int i = 0; i < len; i++)
        begin
            s = $sformatf("%s%c", s, random_char());
        end
        load_pattern(s);
        run_search();
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        void'($urandom(SEED));
        clk       = 1'b0;
        reset     = 1'b1;
        chardata  = '0;
        isstring  = 1'b0;
        ispattern = 1'b0;
        exp_match = 1'b0;
        exp_index = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Literal occurring twice
        try_search("xxabcyabcz", "abc");
        // Wildcard over letters and a space
        try_search("zz a cz", "a.c");
        try_search("q.rs", "..s");
        // Start anchor
        try_search("ab cd", "^ab");
        retry_pattern("^cd");
        try_search("abcd", "^bc");
        // End anchor
        try_search("ab cd", "cd$");
        retry_pattern("ab$");
        try_search("abc", "b$");
        try_search("ab cd ef", "^cd$");
        // No fit, then a new pattern on the kept text
        try_search("hello world", "xyz");
        retry_pattern("wor");

        for (int i = 0; i < RANDOM_RUNS; i++)
        begin
            random_search();
        end

        @(negedge clk);
        @(negedge clk);
        if (valid_count != search_count)
        begin
            abort_run($sformatf("saw %0d result pulses for %0d searches",
                                valid_count, search_count));
        end
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before all searches finished");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+tb
verilog/sme_pkg.sv
verilog/char_buffer.sv
verilog/frame_scanner.sv
verilog/sme_ctrl.sv
verilog/sme_top.sv
tb/sme_tb.sv

// ==== Makefile ====
BIN := obj_dir/Vsme_tb

.PHONY: all run clean

all: run

$(BIN): vlog.f $(wildcard verilog/*.sv tb/*.sv tb/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module sme_tb -f vlog.f

run: $(BIN)
	-./$(BIN) > sim.log 2>&1
	@cat sim.log
	@grep -q '^Simulation finished: PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
